// ==== logic/mpls_egress_pkg.sv ====
////////////////////////////////////////
// MPLS egress shared definitions
////////////////////////////////////////

package mpls_egress_pkg;

    ////////////////////////////////////////
    // Bus and port geometry

    // Bytes per word on the wide input bus
    localparam int BUS_BYTES = 8;

    localparam int NUM_PORTS = 4;

    // Physical port widths in bytes, indexed by port number
    localparam int PORT_BYTES [NUM_PORTS] = '{1, 2, 4, 8};

    ////////////////////////////////////////
    // Buffering

    // Words per port buffer, power of two
    localparam int BUF_DEPTH = 32;

    // Largest packet in input words, stands in for the MTU
    localparam int MAX_PKT_WORDS = 16;

    ////////////////////////////////////////
    // Types

    typedef logic [BUS_BYTES*8-1:0] word_t;

    // Byte enables, contiguous from the least significant byte
    typedef logic [BUS_BYTES-1:0] keep_t;

    typedef logic [1:0] port_idx_t;

    // Word count from 0 to BUF_DEPTH inclusive
    typedef logic [5:0] level_t;

endpackage

// ==== logic/mpls_egress_ctrl.sv ====
////////////////////////////////////////
// MPLS egress packet steering
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_ctrl
    import mpls_egress_pkg::*;
(
    input  var logic                 clk,
    input  var logic                 reset,

    input  var logic                 in_valid,
    input  var word_t                in_data,
    input  var keep_t                in_keep,
    input  var logic                 in_last,
    input  var port_idx_t            in_port,
    output var logic                 in_ready,

    input  var level_t               free_words [NUM_PORTS],
    output var logic [NUM_PORTS-1:0] buf_write,
    output var word_t                buf_data,
    output var keep_t                buf_keep,
    output var logic                 buf_last,

    output var logic [NUM_PORTS-1:0] overflow
);

    typedef enum logic [1:0] {IDLE, FORWARD, DROP} egress_state_t;

    egress_state_t        state_q;
    egress_state_t        state_d;
    port_idx_t            port_q;
    logic                 ready_q;
    logic                 accept;
    logic                 port_exists;
    logic                 has_room;
    logic [NUM_PORTS-1:0] overflow_d;
    logic [NUM_PORTS-1:0] overflow_q;

    assign in_ready = ready_q;
    assign accept   = in_valid && ready_q;

    // Room for a full-size packet must be guaranteed on the first word
    assign port_exists = int'(in_port) < NUM_PORTS;
    assign has_room    = port_exists && (free_words[in_port] >= level_t'(MAX_PKT_WORDS));

    // Payload goes to every buffer, only the strobe selects
    assign buf_data = in_data;
    assign buf_keep = in_keep;
    assign buf_last = in_last;

    assign overflow = overflow_q;

    ////////////////////////////////////////
    // Next state and write strobes

    always_comb begin
        state_d    = state_q;
        buf_write  = '0;
        overflow_d = '0;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (has_room) begin
                        buf_write[in_port] = 1'b1;
                        if (!in_last) begin
                            state_d = FORWARD;
                        end
                    end else begin
                        // Unknown ports are dropped without a pulse
                        if (port_exists) begin
                            overflow_d[in_port] = 1'b1;
                        end
                        if (!in_last) begin
                            state_d = DROP;
                        end
                    end
                end
            end
            FORWARD: begin
                if (accept) begin
                    buf_write[port_q] = 1'b1;
                    if (in_last) begin
                        state_d = IDLE;
                    end
                end
            end
            DROP: begin
                if (accept && in_last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////
    // State registers

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= IDLE;
            port_q     <= '0;
            ready_q    <= 1'b0;
            overflow_q <= '0;
        end else begin
            state_q    <= state_d;
            ready_q    <= 1'b1;
            overflow_q <= overflow_d;
            if (state_q == IDLE && accept) begin
                port_q <= in_port;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress_port_buffer.sv ====
////////////////////////////////////////
// MPLS egress port buffer
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_port_buffer
    import mpls_egress_pkg::*;
(
    input  var logic   clk,
    input  var logic   reset,

    input  var logic   write,
    input  var word_t  wr_data,
    input  var keep_t  wr_keep,
    input  var logic   wr_last,

    output var logic   rd_valid,
    input  var logic   rd_ready,
    output var word_t  rd_data,
    output var keep_t  rd_keep,
    output var logic   rd_last,

    output var level_t free_words
);

    localparam int PTR_W   = $clog2(BUF_DEPTH);
    localparam int ENTRY_W = $bits(word_t) + $bits(keep_t) + 1;

    typedef logic [PTR_W-1:0] ptr_t;

    logic [ENTRY_W-1:0] mem [BUF_DEPTH];
    ptr_t               wr_ptr;
    ptr_t               rd_ptr;
    level_t             count;
    logic               do_write;
    logic               do_read;

    // Head of the queue is always on the read port
    assign rd_valid = (count != '0);
    assign {rd_last, rd_keep, rd_data} = mem[rd_ptr];

    assign free_words = level_t'(BUF_DEPTH) - count;

    assign do_write = write && (count != level_t'(BUF_DEPTH));
    assign do_read  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {wr_last, wr_keep, wr_data};
        end
    end

    // Pointers wrap naturally with a power-of-two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress_width_adapt.sv ====
////////////////////////////////////////
// MPLS egress width down-converter
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mpls_egress_width_adapt
    import mpls_egress_pkg::*;
#(
    parameter int OUT_BYTES = 1
)(
    input  var logic                   clk,
    input  var logic                   reset,

    input  var logic                   rd_valid,
    output var logic                   rd_ready,
    input  var word_t                  rd_data,
    input  var keep_t                  rd_keep,
    input  var logic                   rd_last,

    output var logic                   out_valid,
    input  var logic                   out_ready,
    output var logic [OUT_BYTES*8-1:0] out_data,
    output var logic [OUT_BYTES-1:0]   out_keep,
    output var logic                   out_last
);

    localparam int NUM_CHUNKS = BUS_BYTES / OUT_BYTES;
    localparam int CHUNK_W    = (NUM_CHUNKS > 1) ? $clog2(NUM_CHUNKS) : 1;
    localparam int OUT_BITS   = OUT_BYTES * 8;

    word_t               word_q;
    keep_t               keep_q;
    logic                last_q;
    logic                full_q;
    logic [CHUNK_W-1:0]  idx_q;
    logic [NUM_CHUNKS:0] chunk_used;
    logic                chunk_end;
    logic                load;

    // One flag per chunk with any byte enabled, plus a zero sentinel
    always_comb begin
        chunk_used = '0;
        for (int i = 0; i < NUM_CHUNKS; i++) begin
            chunk_used[i] = |keep_q[i*OUT_BYTES +: OUT_BYTES];
        end
    end

    // Keep is contiguous, so the first empty chunk ends the word
    assign chunk_end = !chunk_used[int'(idx_q) + 1];

    assign out_valid = full_q;
    assign out_data  = word_q[int'(idx_q)*OUT_BITS +: OUT_BITS];
    assign out_keep  = keep_q[int'(idx_q)*OUT_BYTES +: OUT_BYTES];
    assign out_last  = last_q && chunk_end;

    // Next word may load while the final chunk goes out
    assign rd_ready = !full_q || (out_ready && chunk_end);
    assign load     = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= rd_data;
            keep_q <= rd_keep;
            last_q <= rd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else if (load) begin
            full_q <= 1'b1;
            idx_q  <= '0;
        end else if (full_q && out_ready) begin
            if (chunk_end) begin
                full_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/mpls_egress.sv ====
////////////////////////////////////////
// MPLS router egress stage
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mpls_egress
    import mpls_egress_pkg::*;
(
    input  var logic                         clk,
    input  var logic                         reset,

    input  var logic                         in_valid,
    output var logic                         in_ready,
    input  var word_t                        in_data,
    input  var keep_t                        in_keep,
    input  var logic                         in_last,
    input  var port_idx_t                    in_port,

    output var logic                         port0_valid,
    input  var logic                         port0_ready,
    output var logic [PORT_BYTES[0]*8-1:0]   port0_data,
    output var logic [PORT_BYTES[0]-1:0]     port0_keep,
    output var logic                         port0_last,

    output var logic                         port1_valid,
    input  var logic                         port1_ready,
    output var logic [PORT_BYTES[1]*8-1:0]   port1_data,
    output var logic [PORT_BYTES[1]-1:0]     port1_keep,
    output var logic                         port1_last,

    output var logic                         port2_valid,
    input  var logic                         port2_ready,
    output var logic [PORT_BYTES[2]*8-1:0]   port2_data,
    output var logic [PORT_BYTES[2]-1:0]     port2_keep,
    output var logic                         port2_last,

    output var logic                         port3_valid,
    input  var logic                         port3_ready,
    output var logic [PORT_BYTES[3]*8-1:0]   port3_data,
    output var logic [PORT_BYTES[3]-1:0]     port3_keep,
    output var logic                         port3_last,

    output var logic [NUM_PORTS-1:0]         overflow
);

    ////////////////////////////////////////
    // Steering

    logic [NUM_PORTS-1:0] buf_write;
    word_t                buf_data;
    keep_t                buf_keep;
    logic                 buf_last;
    level_t               free_words [NUM_PORTS];
    logic [NUM_PORTS-1:0] port_ready;
    logic [NUM_PORTS-1:0] port_valid;
    logic [NUM_PORTS-1:0] port_last;

    mpls_egress_ctrl ctrl_i (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .in_valid   ( in_valid   ),
        .in_data    ( in_data    ),
        .in_keep    ( in_keep    ),
        .in_last    ( in_last    ),
        .in_port    ( in_port    ),
        .in_ready   ( in_ready   ),
        .free_words ( free_words ),
        .buf_write  ( buf_write  ),
        .buf_data   ( buf_data   ),
        .buf_keep   ( buf_keep   ),
        .buf_last   ( buf_last   ),
        .overflow   ( overflow   )
    );

    ////////////////////////////////////////
    // Per-port buffer and width adapter

    assign port_ready = {port3_ready, port2_ready, port1_ready, port0_ready};

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        localparam int OB = PORT_BYTES[i];

        logic              rd_valid;
        logic              rd_ready;
        word_t             rd_data;
        keep_t             rd_keep;
        logic              rd_last;
        logic [OB*8-1:0]   chunk_data;
        logic [OB-1:0]     chunk_keep;

        mpls_egress_port_buffer buffer_i (
            .clk        ( clk           ),
            .reset      ( reset         ),
            .write      ( buf_write[i]  ),
            .wr_data    ( buf_data      ),
            .wr_keep    ( buf_keep      ),
            .wr_last    ( buf_last      ),
            .rd_valid   ( rd_valid      ),
            .rd_ready   ( rd_ready      ),
            .rd_data    ( rd_data       ),
            .rd_keep    ( rd_keep       ),
            .rd_last    ( rd_last       ),
            .free_words ( free_words[i] )
        );

        mpls_egress_width_adapt #(
            .OUT_BYTES ( OB )
        ) adapt_i (
            .clk       ( clk           ),
            .reset     ( reset         ),
            .rd_valid  ( rd_valid      ),
            .rd_ready  ( rd_ready      ),
            .rd_data   ( rd_data       ),
            .rd_keep   ( rd_keep       ),
            .rd_last   ( rd_last       ),
            .out_valid ( port_valid[i] ),
            .out_ready ( port_ready[i] ),
            .out_data  ( chunk_data    ),
            .out_keep  ( chunk_keep    ),
            .out_last  ( port_last[i]  )
        );
    end

    // Port widths differ, so each port reads its own generate block
    assign port0_valid = port_valid[0];
    assign port0_data  = g_port[0].chunk_data;
    assign port0_keep  = g_port[0].chunk_keep;
    assign port0_last  = port_last[0];

    assign port1_valid = port_valid[1];
    assign port1_data  = g_port[1].chunk_data;
    assign port1_keep  = g_port[1].chunk_keep;
    assign port1_last  = port_last[1];

    assign port2_valid = port_valid[2];
    assign port2_data  = g_port[2].chunk_data;
    assign port2_keep  = g_port[2].chunk_keep;
    assign port2_last  = port_last[2];

    assign port3_valid = port_valid[3];
    assign port3_data  = g_port[3].chunk_data;
    assign port3_keep  = g_port[3].chunk_keep;
    assign port3_last  = port_last[3];

endmodule

`default_nettype wire

// ==== test/mpls_egress_assertions.sv ====
////////////////////////////////////////
// MPLS egress port protocol checks
////////////////////////////////////////

`timescale 1ns/1ps

module mpls_egress_assertions
    import mpls_egress_pkg::*;
(
    input var logic                       clk,
    input var logic                       reset,
    input var logic                       in_ready,
    input var logic                       port0_valid,
    input var logic                       port0_ready,
    input var logic [PORT_BYTES[0]*8-1:0] port0_data,
    input var logic [PORT_BYTES[0]-1:0]   port0_keep,
    input var logic                       port0_last,
    input var logic                       port1_valid,
    input var logic                       port1_ready,
    input var logic [PORT_BYTES[1]*8-1:0] port1_data,
    input var logic [PORT_BYTES[1]-1:0]   port1_keep,
    input var logic                       port1_last,
    input var logic                       port2_valid,
    input var logic                       port2_ready,
    input var logic [PORT_BYTES[2]*8-1:0] port2_data,
    input var logic [PORT_BYTES[2]-1:0]   port2_keep,
    input var logic                       port2_last,
    input var logic                       port3_valid,
    input var logic                       port3_ready,
    input var logic [PORT_BYTES[3]*8-1:0] port3_data,
    input var logic [PORT_BYTES[3]-1:0]   port3_keep,
    input var logic                       port3_last,
    input var logic [NUM_PORTS-1:0]       overflow
);

    int unsigned fail_count = 0;

    // Nonzero and contiguous from bit 0
    function automatic bit keep_ok(input logic [BUS_BYTES:0] k);
        return (k != '0) && ((k & (k + 1'b1)) == '0);
    endfunction

    ////////////////////////////////////////
    // Hold until ready

    hold0: assert property (@(posedge clk) disable iff (reset) port0_valid && !port0_ready
        |=> port0_valid && $stable({port0_data, port0_keep, port0_last}))
    else begin
        fail_count++;
        $error("port 0 changed before ready");
    end
    hold1: assert property (@(posedge clk) disable iff (reset) port1_valid && !port1_ready
        |=> port1_valid && $stable({port1_data, port1_keep, port1_last}))
    else begin
        fail_count++;
        $error("port 1 changed before ready");
    end
    hold2: assert property (@(posedge clk) disable iff (reset) port2_valid && !port2_ready
        |=> port2_valid && $stable({port2_data, port2_keep, port2_last}))
    else begin
        fail_count++;
        $error("port 2 changed before ready");
    end
    hold3: assert property (@(posedge clk) disable iff (reset) port3_valid && !port3_ready
        |=> port3_valid && $stable({port3_data, port3_keep, port3_last}))
    else begin
        fail_count++;
        $error("port 3 changed before ready");
    end

    ////////////////////////////////////////
    // Keep shape, overflow pulses, reset

    keep0: assert property (@(posedge clk) disable iff (reset)
        port0_valid |-> keep_ok(9'(port0_keep)))
    else begin
        fail_count++;
        $error("port 0 keep is empty or has a gap");
    end
    keep1: assert property (@(posedge clk) disable iff (reset)
        port1_valid |-> keep_ok(9'(port1_keep)))
    else begin
        fail_count++;
        $error("port 1 keep is empty or has a gap");
    end
    keep2: assert property (@(posedge clk) disable iff (reset)
        port2_valid |-> keep_ok(9'(port2_keep)))
    else begin
        fail_count++;
        $error("port 2 keep is empty or has a gap");
    end
    keep3: assert property (@(posedge clk) disable iff (reset)
        port3_valid |-> keep_ok(9'(port3_keep)))
    else begin
        fail_count++;
        $error("port 3 keep is empty or has a gap");
    end

    ovf_pulse: assert property (@(posedge clk) disable iff (reset)
        (overflow & $past(overflow)) == '0)
    else begin
        fail_count++;
        $error("overflow held for more than one cycle");
    end

    reset_state: assert property (@(posedge clk) $fell(reset) |-> !in_ready && overflow == '0
        && !port0_valid && !port1_valid && !port2_valid && !port3_valid)
    else begin
        fail_count++;
        $error("outputs active right after reset");
    end

    ready_up: assert property (@(posedge clk) disable iff (reset) !$past(reset) |-> in_ready)
    else begin
        fail_count++;
        $error("in_ready low after reset");
    end

endmodule

bind mpls_egress mpls_egress_assertions assertions_i (.*);

// ==== test/mpls_egress_tb.sv ====
////////////////////////////////////////
// MPLS egress testbench
////////////////////////////////////////

`timescale 1ns/1ps

module mpls_egress_tb
    import mpls_egress_pkg::*;
;

    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 6000;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      in_valid = 1'b0;
    logic      in_ready;
    word_t     in_data = '0;
    keep_t     in_keep = '0;
    logic      in_last = 1'b0;
    port_idx_t in_port = '0;
    logic      port0_valid;
    logic      port1_valid;
    logic      port2_valid;
    logic      port3_valid;
    logic      port0_ready = 1'b1;
    logic      port1_ready = 1'b1;
    logic      port2_ready = 1'b1;
    logic      port3_ready = 1'b1;
    logic [7:0]  port0_data;
    logic [15:0] port1_data;
    logic [31:0] port2_data;
    logic [63:0] port3_data;
    logic [0:0]  port0_keep;
    logic [1:0]  port1_keep;
    logic [3:0]  port2_keep;
    logic [7:0]  port3_keep;
    logic        port0_last;
    logic        port1_last;
    logic        port2_last;
    logic        port3_last;
    logic [NUM_PORTS-1:0] overflow;

    // Scoreboard entries are {packet end, byte}
    logic [8:0]  expected [NUM_PORTS][$];
    logic [8:0]  cur_pkt [$];
    int          cur_port;
    bit          ovf_due = 1'b0;
    int          sent [NUM_PORTS];
    int          delivered [NUM_PORTS];
    int          drops [NUM_PORTS];
    int          errors = 0;
    int          timeouts = 0;
    int unsigned stim_state = 66064;
    int unsigned ready_state = 66064;
    bit          rand_ready = 1'b0;
    bit          hold_port2 = 1'b0;

    mpls_egress mpls_egress_i (.*);

    always #4 clk = ~clk;

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int next_rand(input int n);
        stim_state = lcg_step(stim_state);
        return int'((stim_state >> 16) % n);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error %0t ns: %s", $time, msg);
        errors++;
    endtask

    ////////////////////////////////////////
    // Ready patterns and output scoreboard

    always @(posedge clk) begin
        ready_state = lcg_step(ready_state);
        port0_ready <= rand_ready ? ready_state[16] : 1'b1;
        port1_ready <= rand_ready ? ready_state[18] : 1'b1;
        port2_ready <= hold_port2 ? 1'b0 : (rand_ready ? ready_state[20] : 1'b1);
        port3_ready <= rand_ready ? ready_state[22] : 1'b1;
    end

    task automatic check_chunk(input int port, input logic [63:0] data, input logic [7:0] keep,
                               input logic last, input int width);
        logic [8:0] want;
        logic       end_seen;
        end_seen = 1'b0;
        for (int b = 0; b < width; b++) begin
            if (keep[b]) begin
                if (expected[port].size() == 0) begin
                    report_mismatch($sformatf("port %0d sent an unexpected byte", port));
                end else begin
                    want = expected[port].pop_front();
                    if (want[7:0] != data[b*8 +: 8]) begin
                        report_mismatch($sformatf("port %0d byte %0d is %h, expected %h",
                                                  port, b, data[b*8 +: 8], want[7:0]));
                    end
                    end_seen = want[8];
                end
            end
        end
        if (last != end_seen) begin
            report_mismatch($sformatf("port %0d last is %0b, expected %0b",
                                      port, last, end_seen));
        end
        if (last) begin
            delivered[port]++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (port0_valid && port0_ready) begin
                check_chunk(0, 64'(port0_data), 8'(port0_keep), port0_last, 1);
            end
            if (port1_valid && port1_ready) begin
                check_chunk(1, 64'(port1_data), 8'(port1_keep), port1_last, 2);
            end
            if (port2_valid && port2_ready) begin
                check_chunk(2, 64'(port2_data), 8'(port2_keep), port2_last, 4);
            end
            if (port3_valid && port3_ready) begin
                check_chunk(3, 64'(port3_data), 8'(port3_keep), port3_last, 8);
            end
        end
    end

    ////////////////////////////////////////
    // Packet driver

    // Advance one clock and settle the overflow of the last first word
    task automatic step_cycle();
        logic [NUM_PORTS-1:0] other_ovf;
        @(posedge clk);
        other_ovf = overflow;
        if (ovf_due) begin
            ovf_due = 1'b0;
            other_ovf[cur_port] = 1'b0;
            if (overflow[cur_port]) begin
                drops[cur_port]++;
            end else begin
                foreach (cur_pkt[i]) expected[cur_port].push_back(cur_pkt[i]);
            end
        end
        if (other_ovf != '0) begin
            report_mismatch($sformatf("overflow %b pulsed with no packet to drop", other_ovf));
        end
    endtask

    task automatic send_packet(input int port, input int words, input int last_bytes);
        int    nbytes;
        int    waited;
        word_t data;
        keep_t keep;
        nbytes = (words - 1) * BUS_BYTES + last_bytes;
        cur_pkt.delete();
        for (int b = 0; b < nbytes; b++) begin
            cur_pkt.push_back({b == nbytes - 1, 8'(next_rand(256))});
        end
        cur_port = port;
        sent[port]++;
        for (int w = 0; w < words; w++) begin
            data = '0;
            keep = '0;
            for (int b = 0; b < BUS_BYTES; b++) begin
                if (w * BUS_BYTES + b < nbytes) begin
                    data[b*8 +: 8] = cur_pkt[w*BUS_BYTES + b][7:0];
                    keep[b] = 1'b1;
                end
            end
            in_valid <= 1'b1;
            in_data  <= data;
            in_keep  <= keep;
            in_last  <= (w == words - 1);
            in_port  <= port_idx_t'(port);
            waited = 0;
            do begin
                step_cycle();
                waited++;
            end while (!in_ready && waited < WAIT_LIMIT);
            if (!in_ready) begin
                $display("Timeout: the DUT never accepted a word on the input stream");
                timeouts++;
                break;
            end
            if (w == 0) ovf_due = 1'b1;
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        // Idle gap between packets
        step_cycle();
    endtask

    function automatic bit queues_empty();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (expected[p].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!queues_empty() && waited < DRAIN_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!queues_empty()) begin
            $display("Timeout: expected bytes were still missing on the ports");
            timeouts++;
        end
    endtask

    task automatic send_random();
        send_packet(next_rand(NUM_PORTS), 1 + next_rand(MAX_PKT_WORDS), 1 + next_rand(BUS_BYTES));
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int base_sent;
        int base_del;
        int base_drop;
        int asrt_fails;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        step_cycle();

        // Byte-exact delivery, drained after every packet
        for (int i = 0; i < 30; i++) begin
            send_random();
            wait_drain();
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (drops[p] != 0) report_mismatch($sformatf("port %0d dropped with ready held", p));
        end

        // Partial last words on every width
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_packet(p, 2, 3);
            send_packet(p, 1, 5);
            send_packet(p, 3, 7);
        end
        wait_drain();

        // Port 2 stalled while port 3 keeps running
        base_sent = sent[2];
        base_del  = delivered[2];
        base_drop = drops[2];
        hold_port2 <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            send_packet(2, MAX_PKT_WORDS, 8);
            send_packet(3, 4, 6);
        end
        repeat (20) step_cycle();
        if (expected[3].size() != 0) begin
            report_mismatch("port 3 traffic stalled while port 2 was held");
        end
        hold_port2 <= 1'b0;
        wait_drain();
        if (drops[2] == base_drop) begin
            report_mismatch("port 2 never raised overflow while stalled");
        end
        if ((delivered[2] - base_del) + (drops[2] - base_drop) != sent[2] - base_sent) begin
            report_mismatch("port 2 delivered plus dropped packets differ from sent packets");
        end

        // Random ready on every port
        rand_ready <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_random();
        end
        wait_drain();

        asrt_fails = int'(mpls_egress_i.assertions_i.fail_count);
        $display("Closing report: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, asrt_fails);
        if (errors == 0 && timeouts == 0 && asrt_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
logic/mpls_egress_pkg.sv
logic/mpls_egress_ctrl.sv
logic/mpls_egress_port_buffer.sv
logic/mpls_egress_width_adapt.sv
logic/mpls_egress.sv
test/mpls_egress_assertions.sv
test/mpls_egress_tb.sv

// ==== Makefile ====
# Verilator flow for the MPLS egress stage

VERILATOR ?= verilator
TOP       ?= mpls_egress_tb
RTL_TOP   ?= mpls_egress
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
